//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = dma_tb
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/dma_checker.sv
/* Testbench checker for the DMA controller. Snoops descriptor fetches and
   status write-backs, predicts each written word and counts errors */
module dma_checker (
   input  logic                   wb_clk_i,
   input  logic                   wb_rst_i,
   input  logic                   cfg_we_i,
   input  dma_cfg_pkg::reg_addr_e cfg_adr_i,
   input  logic [31:0]            cfg_dat_i,
   input  logic [31:0]            cfg_dat_o,
   input  logic                   wbm_cyc_o,
   input  logic                   wbm_stb_o,
   input  logic                   wbm_we_o,
   input  logic [3:0]             wbm_sel_o,
   input  logic [31:0]            wbm_adr_o,
   input  logic [31:0]            wbm_dat_o,
   input  logic                   wbm_ack_i,
   input  logic [31:0]            wbm_dat_i,
   input  logic                   irq_o,
   input  logic                   exp_valid_i,   // compare cfg_dat_o this cycle
   input  logic [31:0]            exp_dat_i,
   output int                     errors_o,
   output int                     checks_o
);
   import dma_cfg_pkg::*;

   logic        rst_q = 1'b1;
   logic        irq_q = 1'b0;
   logic        irq_pend = 1'b0;    // some fetched descriptor asked for irq
   int          fbeat = 0;
   int          wcnt = 0;
   logic [31:0] ctl = '0;
   logic [31:0] stat = '0;
   logic [31:0] exp_w;
   logic [13:0] len;

   initial begin
      errors_o = 0;
      checks_o = 0;
   end

   // last descriptor wrote four status words if bit 7 asked for it, else none
   task automatic check_wb_beats;
      checks_o++;
      if (wcnt != (ctl[7] ? 4 : 0)) begin
         errors_o++;
         $display("[ERROR] %0t: write-back had %0d beats, expected %0d", $time,
                  wcnt, ctl[7] ? 4 : 0);
      end
   endtask

   always @(posedge wb_clk_i) begin
      if (!wb_rst_i) begin
         if (rst_q) begin
            checks_o++;
            if (wbm_cyc_o || wbm_stb_o || irq_o) begin
               errors_o++;
               $display("[ERROR] %0t: bus or irq active after reset", $time);
            end
         end
         if (exp_valid_i) begin
            checks_o++;
            if (cfg_dat_o !== exp_dat_i) begin
               errors_o++;
               $display("[ERROR] %0t: reg %s read %h, expected %h", $time,
                        cfg_adr_i.name(), cfg_dat_o, exp_dat_i);
            end
            if (cfg_adr_i == REG_STATUS && irq_o !== exp_dat_i[STAT_IRQ_BIT]) begin
               errors_o++;
               $display("[ERROR] %0t: irq_o is %b, expected %b", $time,
                        irq_o, exp_dat_i[STAT_IRQ_BIT]);
            end
            if (cfg_adr_i == REG_DAR)
               check_wb_beats();
         end
         if (cfg_we_i && cfg_adr_i == REG_INT_CLR && cfg_dat_i[0])
            irq_pend = 1'b0;
         if (irq_o && !irq_q && !irq_pend) begin
            errors_o++;
            $display("[ERROR] %0t: irq_o rose without an irq_en descriptor", $time);
         end
         irq_q = irq_o;
         if (wbm_cyc_o && wbm_stb_o && wbm_ack_i && wbm_sel_o !== 4'hF) begin
            errors_o++;
            $display("[ERROR] %0t: byte select %h, expected f", $time, wbm_sel_o);
         end
         if (wbm_cyc_o && wbm_stb_o && wbm_ack_i && !wbm_we_o) begin
            if (fbeat == 0) begin
               check_wb_beats();
               wcnt = 0;
            end
            if (fbeat == 1) begin
               ctl = wbm_dat_i;
               if (wbm_dat_i[15])
                  irq_pend = 1'b1;
            end
            if (fbeat == 2)
               stat = {wbm_dat_i[31:3], 3'b000};
            fbeat = (fbeat + 1) % 4;
         end else if (wbm_cyc_o && wbm_stb_o && wbm_ack_i) begin
            len = ctl[13:0];
            case (wcnt)
               0:       exp_w = 32'(len);
               1:       exp_w = (len == 0) ? 32'd1 : 32'd0;
               2:       exp_w = (len == 0) ? 32'd1 : 32'(len);
               default: exp_w = ctl;
            endcase
            checks_o++;
            if (wcnt > 3) begin
               errors_o++;
               $display("[ERROR] %0t: extra write-back beat", $time);
            end else if (wbm_adr_o !== stat + 32'(4 * wcnt) || wbm_dat_o !== exp_w) begin
               errors_o++;
               $display("[ERROR] %0t: write beat %0d adr %h dat %h, expected %h %h", $time,
                        wcnt, wbm_adr_o, wbm_dat_o, stat + 32'(4 * wcnt), exp_w);
            end
            wcnt++;
         end
      end
      rst_q = wb_rst_i;
   end

endmodule

//--- bench/dma_tb.sv
/* Testbench top for the DMA controller. Runs a table of descriptors through
   the DUT against a Wishbone memory model with random wait states */
module dma_tb;
   import dma_cfg_pkg::*;

   typedef struct packed {
      logic [31:0] adr;
      logic [13:0] len;
      logic        chain;
      logic        irq_en;
      logic        wback;
      logic        kick;      // software writes NDAR for this row
      logic        hold;      // NDAR written while disabled
      logic [31:0] dar;       // DAR once the chain completes
   } row_t;

   localparam int N_ROWS = 7;
   localparam row_t ROWS [N_ROWS] = '{
      '{32'h010, 14'd5, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h010},
      '{32'h040, 14'd3, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 32'h0A0},
      '{32'h070, 14'd7, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0A0},
      '{32'h0A0, 14'd2, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h0A0},
      '{32'h0D0, 14'd4, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 32'h0D0},
      '{32'h100, 14'd0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h100},
      '{32'h130, 14'd6, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 32'h130}
   };

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        cfg_we_i;
   reg_addr_e   cfg_adr_i;
   logic [31:0] cfg_dat_i;
   logic [31:0] cfg_dat_o;
   logic        wbm_cyc_o;
   logic        wbm_stb_o;
   logic        wbm_we_o;
   logic        wbm_ack_i = 1'b0;
   logic        irq_o;
   logic [3:0]  wbm_sel_o;
   logic [31:0] wbm_adr_o;
   logic [31:0] wbm_dat_o;
   logic [31:0] wbm_dat_i = '0;
   logic        exp_valid;
   logic [31:0] exp_dat;
   int          errors;
   int          checks;
   logic [31:0] mem [0:255];
   int          seed = 55;
   int          wait_cnt;
   logic        irq_exp;

   function automatic logic [31:0] ctrl_word(input row_t r);
      return 32'(r.len) | (32'(r.chain) << 14) | (32'(r.irq_en) << 15) | (32'(r.wback) << 7);
   endfunction

   dma_top UUT (.*);

   dma_checker u_chk (.*, .exp_valid_i(exp_valid), .exp_dat_i(exp_dat),
                      .errors_o(errors), .checks_o(checks));

   initial begin
      wb_clk_i = 1'b0;
      forever #20 wb_clk_i = ~wb_clk_i;
   end

   // memory slave, descriptor images are loaded while reset is held
   always @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         wbm_ack_i <= 1'b0;
         wbm_dat_i <= '0;
         wait_cnt  <= 0;
         for (int i = 0; i < 256; i++)
            mem[i] <= {16'hC0DE, i[7:0], ~i[7:0]};
         for (int r = 0; r < N_ROWS; r++) begin
            mem[ROWS[r].adr[9:2]]        <= ROWS[r].chain ? ROWS[(r + 1) % N_ROWS].adr : '0;
            mem[ROWS[r].adr[9:2] + 8'd1] <= ctrl_word(ROWS[r]);
            mem[ROWS[r].adr[9:2] + 8'd2] <= ROWS[r].adr + 32'h200;
            mem[ROWS[r].adr[9:2] + 8'd3] <= '0;
         end
      end else begin
         wbm_ack_i <= 1'b0;
         if (wbm_cyc_o && wbm_stb_o && !wbm_ack_i) begin
            if (wait_cnt == 0) begin
               wbm_ack_i <= 1'b1;
               if (wbm_we_o)
                  mem[wbm_adr_o[9:2]] <= wbm_dat_o;
               else
                  wbm_dat_i <= mem[wbm_adr_o[9:2]];
               wait_cnt <= $unsigned($random(seed)) % 4;   // 0 to 3 wait cycles
            end else begin
               wait_cnt <= wait_cnt - 1;
            end
         end
      end
   end

   task automatic timeout_fail(input string what);
      $display("timeout waiting for %s", what);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
   endtask

   task automatic write_reg(input reg_addr_e adr, input logic [31:0] dat);
      @(posedge wb_clk_i);
      cfg_we_i  <= 1'b1;
      cfg_adr_i <= adr;
      cfg_dat_i <= dat;
      @(posedge wb_clk_i);
      cfg_we_i  <= 1'b0;
   endtask

   task automatic read_expect(input reg_addr_e adr, input logic [31:0] dat);
      @(posedge wb_clk_i);
      cfg_adr_i <= adr;
      exp_valid <= 1'b1;
      exp_dat   <= dat;
      @(posedge wb_clk_i);
      exp_valid <= 1'b0;
   endtask

   task automatic wait_busy(input logic lvl, input int limit, input string what);
      int n;
      n = 0;
      @(posedge wb_clk_i);
      cfg_adr_i <= REG_STATUS;
      @(negedge wb_clk_i);
      while (cfg_dat_o[0] !== lvl) begin
         if (n >= limit)
            timeout_fail(what);
         n++;
         @(negedge wb_clk_i);
      end
   endtask

   initial begin
      cfg_we_i  = 1'b0;
      cfg_adr_i = REG_CTRL;
      cfg_dat_i = '0;
      exp_valid = 1'b0;
      exp_dat   = '0;
      wb_rst_i  = 1'b1;
      repeat (4) @(posedge wb_clk_i);
      wb_rst_i <= 1'b0;
      read_expect(REG_STATUS, 32'd0);
      for (int r = 0; r < N_ROWS; r++) begin
         if (ROWS[r].kick) begin
            irq_exp = ROWS[r].irq_en;
            for (int j = r; ROWS[j].chain && j + 1 < N_ROWS; j++)
               irq_exp = irq_exp | ROWS[j + 1].irq_en;
            if (ROWS[r].hold) begin
               write_reg(REG_CTRL, 32'd0);
               write_reg(REG_NDAR, ROWS[r].adr);
               repeat (10) read_expect(REG_STATUS, 32'd0);   // no fetch while disabled
            end else begin
               write_reg(REG_NDAR, ROWS[r].adr);
            end
            write_reg(REG_CTRL, 32'd1);
            wait_busy(1'b1, 50, "busy to rise");
            wait_busy(1'b0, 5000, "descriptor chain to finish");
            read_expect(REG_STATUS, {30'd0, irq_exp, 1'b0});
            read_expect(REG_DAR, ROWS[r].dar);
            if (irq_exp) begin
               write_reg(REG_INT_CLR, 32'd1);
               read_expect(REG_STATUS, 32'd0);
            end
         end
      end
      repeat (4) @(posedge wb_clk_i);
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

//--- design/dma_cfg_pkg.sv
/* Configuration-side definitions for the DMA controller. The register offsets,
   register bit positions and the configuration word passed to the controller */
package dma_cfg_pkg;

   localparam int REG_AW  = 3;               // config port address width
   localparam int ADR_LSB = 3;               // descriptors sit on 8-byte boundaries
   localparam int ADR_W   = 32 - ADR_LSB;    // stored descriptor address width

   // register bit positions
   localparam int CTRL_EN_BIT   = 0;
   localparam int STAT_BUSY_BIT = 0;
   localparam int STAT_IRQ_BIT  = 1;
   localparam int INT_CLR_BIT   = 0;

   typedef enum logic [REG_AW-1:0] {
      REG_CTRL    = 3'd0,    // bit0 enable
      REG_NDAR    = 3'd1,    // next descriptor address, sets dirty
      REG_STATUS  = 3'd2,    // bit0 busy, bit1 irq
      REG_INT_CLR = 3'd3,    // write 1 to bit0 to drop irq
      REG_DAR     = 3'd4     // last completed descriptor, read-only
   } reg_addr_e;

   // handed from the register block to the descriptor controller
   typedef struct packed {
      logic             enable;
      logic [ADR_W-1:0] ndar;
      logic             ndar_dirty;
   } cfg_t;

endpackage

//--- design/dma_desc_ctrl.sv
/* Descriptor controller acting as Wishbone master. It fetches each 4-word descriptor,
   starts the transfer engine, writes the status block back and follows the chain */
module dma_desc_ctrl (
   input  logic                                 wb_clk_i,
   input  logic                                 wb_rst_i,
   input  dma_cfg_pkg::cfg_t                    cfg_i,
   output logic                                 ndar_clr_o,
   output logic                                 done_set_o,
   output logic [dma_cfg_pkg::ADR_W-1:0]        done_adr_o,
   output logic                                 irq_set_o,
   output logic                                 busy_o,
   output dma_desc_pkg::wb_req_t                wbm_o,
   input  logic                                 wbm_ack_i,
   input  logic [31:0]                          wbm_dat_i,
   output logic                                 xfer_start_o,
   output logic [dma_desc_pkg::DESC_LEN_W-1:0]  xfer_len_o,
   input  logic                                 xfer_done_i,
   input  dma_desc_pkg::xfer_rpt_t              xfer_rpt_i
);
   import dma_cfg_pkg::*;
   import dma_desc_pkg::*;

   ctrl_state_e      state_q;
   logic             cyc_q;
   logic             stb_q;
   logic             we_q;
   logic [31:0]      adr_q;
   logic [BEAT_W-1:0] beat_q;
   logic             ndar_clr_q;
   logic [ADR_W-1:0] cur_adr_q;
   desc_t            desc_q;
   logic [31:0]      ctl_word_q;
   logic [31:0]      wb_word;
   logic             beat_ack;
   logic             last_beat;
   logic             fetch_go;
   logic [ADR_W-1:0] fetch_adr;
   logic             wback_go;

   assign beat_ack  = stb_q && wbm_ack_i;
   assign last_beat = beat_q == BEAT_W'(DESC_WORDS - 1);
   assign fetch_go  = (state_q == S_IDLE && cfg_i.enable && cfg_i.ndar_dirty) ||
                      (state_q == S_NEXT && desc_q.chain);
   assign fetch_adr = (state_q == S_IDLE) ? cfg_i.ndar : desc_q.next_desc;
   assign wback_go  = (state_q == S_RUN) && xfer_done_i && desc_q.wback;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state_q    <= S_IDLE;
         cyc_q      <= 1'b0;
         stb_q      <= 1'b0;
         we_q       <= 1'b0;
         beat_q     <= '0;
         ndar_clr_q <= 1'b0;
      end else begin
         ndar_clr_q <= 1'b0;
         case (state_q)
            S_IDLE, S_NEXT: begin
               if (fetch_go) begin
                  ndar_clr_q <= (state_q == S_IDLE);   // software address consumed
                  cyc_q      <= 1'b1;
                  stb_q      <= 1'b1;
                  we_q       <= 1'b0;
                  beat_q     <= '0;
                  state_q    <= S_FETCH;
               end else begin
                  state_q    <= S_IDLE;                // end of chain
               end
            end
            S_FETCH: begin
               if (beat_ack) begin
                  beat_q <= beat_q + BEAT_W'(1);
                  if (last_beat) begin
                     cyc_q   <= 1'b0;
                     stb_q   <= 1'b0;
                     state_q <= S_START;
                  end
               end
            end
            S_START: state_q <= S_RUN;                 // one-cycle engine kick
            S_RUN: begin
               if (wback_go) begin
                  cyc_q   <= 1'b1;
                  stb_q   <= 1'b1;
                  we_q    <= 1'b1;
                  beat_q  <= '0;
                  state_q <= S_WBACK;
               end else if (xfer_done_i) begin
                  state_q <= S_NEXT;
               end
            end
            S_WBACK: begin
               if (beat_ack) begin
                  beat_q <= beat_q + BEAT_W'(1);
                  if (last_beat) begin
                     cyc_q   <= 1'b0;
                     stb_q   <= 1'b0;
                     we_q    <= 1'b0;
                     state_q <= S_NEXT;
                  end
               end
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   // bus address and the fetched descriptor
   always_ff @(posedge wb_clk_i) begin
      if (fetch_go) begin
         adr_q     <= {fetch_adr, {ADR_LSB{1'b0}}};
         cur_adr_q <= fetch_adr;
      end else if (wback_go) begin
         adr_q <= {desc_q.stat_adr, {ADR_LSB{1'b0}}};
      end else if (beat_ack) begin
         adr_q <= adr_q + 32'd4;
      end
      if (beat_ack && !we_q) begin
         case (beat_q)
            DW_NEXT: desc_q.next_desc <= wbm_dat_i[31:ADR_LSB];
            DW_CTRL: begin
               ctl_word_q    <= wbm_dat_i;
               desc_q.len    <= wbm_dat_i[DESC_LEN_W-1:0];
               desc_q.chain  <= wbm_dat_i[DESC_CHAIN_BIT];
               desc_q.irq_en <= wbm_dat_i[DESC_IRQ_BIT];
               desc_q.wback  <= wbm_dat_i[DESC_WB_BIT];
            end
            DW_STAT: desc_q.stat_adr <= wbm_dat_i[31:ADR_LSB];
            default: ;                                 // reserved word
         endcase
      end
   end

   always_comb begin
      wb_word = '0;
      case (beat_q)
         WB_OCNT:   wb_word = 32'(xfer_rpt_i.ocnt);
         WB_ERR:    wb_word = 32'(xfer_rpt_i.err);
         WB_CYCLES: wb_word = xfer_rpt_i.cycles;
         WB_CTRL:   wb_word = ctl_word_q;
         default:   ;
      endcase
   end

   assign wbm_o = '{cyc: cyc_q, stb: stb_q, we: we_q, sel: 4'b1111,
                    adr: adr_q, dat: we_q ? wb_word : 32'h0};

   assign ndar_clr_o   = ndar_clr_q;
   assign done_set_o   = state_q == S_NEXT;
   assign done_adr_o   = cur_adr_q;
   assign irq_set_o    = (state_q == S_NEXT) && desc_q.irq_en;
   assign busy_o       = state_q != S_IDLE;
   assign xfer_start_o = state_q == S_START;
   assign xfer_len_o   = desc_q.len;

   a_stb_in_cyc: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      stb_q |-> cyc_q && (state_q == S_FETCH || state_q == S_WBACK))
      else $error("stb high outside a bus cycle");

   // a stalled beat keeps its request until the slave acks
   a_hold_on_stall: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      stb_q && !wbm_ack_i |=> stb_q && $stable(adr_q) && $stable(wbm_o.dat))
      else $error("request changed while waiting for ack");

endmodule

//--- design/dma_desc_pkg.sv
/* Descriptor-side definitions. Descriptor and status block layout, the Wishbone
   master request, controller states and the transfer engine report */
package dma_desc_pkg;

   localparam int DESC_WORDS     = 4;
   localparam int BEAT_W         = $clog2(DESC_WORDS);
   localparam int DESC_LEN_W     = 14;
   localparam int DESC_WB_BIT    = 7;
   localparam int DESC_CHAIN_BIT = 14;
   localparam int DESC_IRQ_BIT   = 15;

   // descriptor words in fetch order, word 3 is reserved
   localparam int DW_NEXT = 0;
   localparam int DW_CTRL = 1;
   localparam int DW_STAT = 2;

   // status block words in write-back order
   localparam int WB_OCNT   = 0;
   localparam int WB_ERR    = 1;
   localparam int WB_CYCLES = 2;
   localparam int WB_CTRL   = 3;

   localparam logic [2:0] ERR_NONE     = 3'd0;
   localparam logic [2:0] ERR_ZERO_LEN = 3'd1;

   typedef struct packed {
      logic [dma_cfg_pkg::ADR_W-1:0] next_desc;
      logic [DESC_LEN_W-1:0]         len;
      logic                          chain;
      logic                          irq_en;
      logic                          wback;
      logic [dma_cfg_pkg::ADR_W-1:0] stat_adr;
   } desc_t;

   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [3:0]  sel;
      logic [31:0] adr;
      logic [31:0] dat;
   } wb_req_t;

   typedef enum logic [2:0] {S_IDLE, S_FETCH, S_START, S_RUN, S_WBACK, S_NEXT} ctrl_state_e;

   typedef struct packed {
      logic [15:0] ocnt;
      logic [2:0]  err;
      logic [31:0] cycles;
   } xfer_rpt_t;

endpackage

//--- design/dma_regs.sv
/* Software register block of the DMA controller. Written through a plain strobe
   port, it feeds enable and the next descriptor address to the controller */
module dma_regs (
   input  logic                             wb_clk_i,
   input  logic                             wb_rst_i,
   input  logic                             cfg_we_i,
   input  dma_cfg_pkg::reg_addr_e           cfg_adr_i,
   input  logic [31:0]                      cfg_dat_i,
   output logic [31:0]                      cfg_dat_o,
   output dma_cfg_pkg::cfg_t                cfg_o,
   input  logic                             ndar_clr_i,
   input  logic                             done_set_i,
   input  logic [dma_cfg_pkg::ADR_W-1:0]    done_adr_i,
   input  logic                             irq_set_i,
   input  logic                             busy_i,
   output logic                             irq_o
);
   import dma_cfg_pkg::*;

   logic             enable_q;
   logic [ADR_W-1:0] ndar_q;
   logic             dirty_q;
   logic [ADR_W-1:0] dar_q;
   logic             irq_q;
   logic             wr_ctrl;
   logic             wr_ndar;
   logic             int_clr;

   assign wr_ctrl = cfg_we_i && (cfg_adr_i == REG_CTRL);
   assign wr_ndar = cfg_we_i && (cfg_adr_i == REG_NDAR);
   assign int_clr = cfg_we_i && (cfg_adr_i == REG_INT_CLR) && cfg_dat_i[INT_CLR_BIT];

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         enable_q <= 1'b0;
         ndar_q   <= '0;
         dirty_q  <= 1'b0;
         dar_q    <= '0;
         irq_q    <= 1'b0;
      end else begin
         if (wr_ctrl)
            enable_q <= cfg_dat_i[CTRL_EN_BIT];
         if (wr_ndar) begin
            ndar_q  <= cfg_dat_i[31:ADR_LSB];
            dirty_q <= 1'b1;                 // fresh address beats a pending clear
         end else if (ndar_clr_i) begin
            dirty_q <= 1'b0;
         end
         if (done_set_i)
            dar_q <= done_adr_i;
         if (int_clr)
            irq_q <= 1'b0;                   // clear wins over a same-cycle set
         else if (irq_set_i)
            irq_q <= 1'b1;
      end
   end

   always_comb begin
      cfg_dat_o = '0;
      case (cfg_adr_i)
         REG_CTRL:   cfg_dat_o[CTRL_EN_BIT] = enable_q;
         REG_NDAR:   cfg_dat_o = {ndar_q, {ADR_LSB{1'b0}}};
         REG_STATUS: begin
            cfg_dat_o[STAT_BUSY_BIT] = busy_i;
            cfg_dat_o[STAT_IRQ_BIT]  = irq_q;
         end
         REG_DAR:    cfg_dat_o = {dar_q, {ADR_LSB{1'b0}}};
         default:    ;                       // INT_CLR reads as zero
      endcase
   end

   assign cfg_o = '{enable: enable_q, ndar: ndar_q, ndar_dirty: dirty_q};
   assign irq_o = irq_q;

   // the controller only consumes an address that software actually posted
   a_clr_needs_dirty: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      ndar_clr_i |-> dirty_q)
      else $error("ndar clear without a pending NDAR write");

endmodule

//--- design/dma_top.sv
/* DMA controller top level. Ties the register block, descriptor controller and
   transfer engine together and puts the Wishbone master request on flat ports */
module dma_top (
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   input  logic                    cfg_we_i,
   input  dma_cfg_pkg::reg_addr_e  cfg_adr_i,
   input  logic [31:0]             cfg_dat_i,
   output logic [31:0]             cfg_dat_o,
   output logic                    wbm_cyc_o,
   output logic                    wbm_stb_o,
   output logic                    wbm_we_o,
   output logic [3:0]              wbm_sel_o,
   output logic [31:0]             wbm_adr_o,
   output logic [31:0]             wbm_dat_o,
   input  logic                    wbm_ack_i,
   input  logic [31:0]             wbm_dat_i,
   output logic                    irq_o
);
   import dma_cfg_pkg::*;
   import dma_desc_pkg::*;

   cfg_t                  cfg;
   logic                  ndar_clr;
   logic                  done_set;
   logic [ADR_W-1:0]      done_adr;
   logic                  irq_set;
   logic                  busy;
   wb_req_t               wbm;
   logic                  xfer_start;
   logic [DESC_LEN_W-1:0] xfer_len;
   logic                  xfer_done;
   xfer_rpt_t             xfer_rpt;

   dma_regs u_regs (
      .wb_clk_i   (wb_clk_i),
      .wb_rst_i   (wb_rst_i),
      .cfg_we_i   (cfg_we_i),
      .cfg_adr_i  (cfg_adr_i),
      .cfg_dat_i  (cfg_dat_i),
      .cfg_dat_o  (cfg_dat_o),
      .cfg_o      (cfg),
      .ndar_clr_i (ndar_clr),
      .done_set_i (done_set),
      .done_adr_i (done_adr),
      .irq_set_i  (irq_set),
      .busy_i     (busy),
      .irq_o      (irq_o)
   );

   dma_desc_ctrl u_ctrl (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .cfg_i        (cfg),
      .ndar_clr_o   (ndar_clr),
      .done_set_o   (done_set),
      .done_adr_o   (done_adr),
      .irq_set_o    (irq_set),
      .busy_o       (busy),
      .wbm_o        (wbm),
      .wbm_ack_i    (wbm_ack_i),
      .wbm_dat_i    (wbm_dat_i),
      .xfer_start_o (xfer_start),
      .xfer_len_o   (xfer_len),
      .xfer_done_i  (xfer_done),
      .xfer_rpt_i   (xfer_rpt)
   );

   dma_xfer_engine u_engine (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .start_i  (xfer_start),
      .len_i    (xfer_len),
      .done_o   (xfer_done),
      .rpt_o    (xfer_rpt)
   );

   assign wbm_cyc_o = wbm.cyc;
   assign wbm_stb_o = wbm.stb;
   assign wbm_we_o  = wbm.we;
   assign wbm_sel_o = wbm.sel;
   assign wbm_adr_o = wbm.adr;
   assign wbm_dat_o = wbm.dat;

endmodule

//--- design/dma_xfer_engine.sv
/* Transfer engine model. Counts out the descriptor length after a start pulse,
   then pulses done and holds the output count, error code and busy cycles */
module dma_xfer_engine (
   input  logic                                 wb_clk_i,
   input  logic                                 wb_rst_i,
   input  logic                                 start_i,
   input  logic [dma_desc_pkg::DESC_LEN_W-1:0]  len_i,
   output logic                                 done_o,
   output dma_desc_pkg::xfer_rpt_t              rpt_o
);
   import dma_desc_pkg::*;

   logic                  busy_q;
   logic [DESC_LEN_W-1:0] cnt_q;
   logic [DESC_LEN_W-1:0] len_q;
   logic [31:0]           cyc_cnt_q;
   logic                  last;

   assign last   = cnt_q == DESC_LEN_W'(1);
   assign done_o = busy_q && last;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         busy_q    <= 1'b0;
         cnt_q     <= '0;
         cyc_cnt_q <= '0;
      end else if (start_i) begin
         busy_q    <= 1'b1;
         cnt_q     <= (len_i == '0) ? DESC_LEN_W'(1) : len_i;   // zero length still takes a cycle
         cyc_cnt_q <= '0;
      end else if (busy_q) begin
         cnt_q     <= cnt_q - DESC_LEN_W'(1);
         cyc_cnt_q <= cyc_cnt_q + 32'd1;
         if (last)
            busy_q <= 1'b0;
      end
   end

   // report stays put until the next start
   always_ff @(posedge wb_clk_i) begin
      if (start_i)
         len_q <= len_i;
      if (done_o) begin
         rpt_o.ocnt   <= 16'(len_q);
         rpt_o.err    <= (len_q == '0) ? ERR_ZERO_LEN : ERR_NONE;
         rpt_o.cycles <= cyc_cnt_q + 32'd1;   // includes the done cycle
      end
   end

   a_no_restart: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
      start_i |-> !busy_q)
      else $error("engine started while still busy");

endmodule

//--- filelist.f
design/dma_cfg_pkg.sv
design/dma_desc_pkg.sv
design/dma_regs.sv
design/dma_desc_ctrl.sv
design/dma_xfer_engine.sv
design/dma_top.sv
bench/dma_checker.sv
bench/dma_tb.sv
